// File: hdl/rv32_backend.sv
`timescale 1ns/1ps

module rv32_backend (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_valid,
    input  rv32_pkg::issue_t            issue,
    input  logic                        flush,
    output rv32_trace_pkg::retire_rec_t retire
);

    rv32_pkg::reg_idx_t   rs1;
    rv32_pkg::reg_idx_t   rs2;
    rv32_pkg::word_t      rs1_value;
    rv32_pkg::word_t      rs2_value;
    rv32_pkg::stage_t     stage;
    rv32_pkg::reg_write_t reg_write;   // also the forwarding source.

    rv32_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .reg_write (reg_write)
    );

    rv32_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .fwd         (reg_write),
        .stage       (stage)
    );

    rv32_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .stage     (stage),
        .reg_write (reg_write),
        .retire    (retire)
    );

endmodule

// File: hdl/rv32_execute.sv
`timescale 1ns/1ps

module rv32_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  rv32_pkg::issue_t     issue,
    output rv32_pkg::reg_idx_t   rs1,
    output rv32_pkg::reg_idx_t   rs2,
    input  rv32_pkg::word_t      rs1_value,
    input  rv32_pkg::word_t      rs2_value,
    input  rv32_pkg::reg_write_t fwd,
    output rv32_pkg::stage_t     stage
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    rv32_pkg::word_t op_a;      // rs1 after forwarding.
    rv32_pkg::word_t rs2_fwd;   // rs2 after forwarding.
    rv32_pkg::word_t op_b;
    logic [4:0]      shamt;
    rv32_pkg::word_t result;
    logic            trap;

    assign rs1 = issue.rs1;
    assign rs2 = issue.rs2;

    // writeback result bypasses the regfile write of the same cycle.
    assign fwd_rs1 = fwd.en && (fwd.addr == issue.rs1) && (issue.rs1 != '0);
    assign fwd_rs2 = fwd.en && (fwd.addr == issue.rs2) && (issue.rs2 != '0);

    assign op_a    = fwd_rs1 ? fwd.data : rs1_value;
    assign rs2_fwd = fwd_rs2 ? fwd.data : rs2_value;
    assign op_b    = issue.use_imm ? issue.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        trap   = 1'b0;
        result = '0;
        case (issue.op)
            rv32_pkg::op_add: begin
                result = op_a + op_b;
            end
            rv32_pkg::op_sub: begin
                result = op_a - op_b;
            end
            rv32_pkg::op_and: begin
                result = op_a & op_b;
            end
            rv32_pkg::op_or: begin
                result = op_a | op_b;
            end
            rv32_pkg::op_xor: begin
                result = op_a ^ op_b;
            end
            rv32_pkg::op_sll: begin
                result = op_a << shamt;
            end
            rv32_pkg::op_srl: begin
                result = op_a >> shamt;
            end
            rv32_pkg::op_sra: begin
                result = $signed(op_a) >>> shamt;
            end
            rv32_pkg::op_slt: begin
                result = rv32_pkg::word_t'($signed(op_a) < $signed(op_b));
            end
            rv32_pkg::op_sltu: begin
                result = rv32_pkg::word_t'(op_a < op_b);
            end
            default: begin
                trap = 1'b1;   // op_illegal and unused codes.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= issue_valid;
        end
        stage.trap      <= trap;
        stage.rs1       <= issue.rs1;
        stage.rs2       <= issue.rs2;
        stage.rs1_value <= op_a;
        stage.rs2_value <= rs2_fwd;   // register value, even in imm form.
        stage.rd        <= issue.rd;
        stage.rd_write  <= issue.rd_write;
        stage.result    <= result;
        stage.pc        <= issue.pc;
    end

endmodule

// File: hdl/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_add     = 4'h0,
        op_sub     = 4'h1,
        op_and     = 4'h2,
        op_or      = 4'h3,
        op_xor     = 4'h4,
        op_sll     = 4'h5,
        op_srl     = 4'h6,
        op_sra     = 4'h7,
        op_slt     = 4'h8,
        op_sltu    = 4'h9,
        op_illegal = 4'hf   // any undefined encoding traps as well.
    } alu_op_t;

    typedef struct packed {
        alu_op_t  op;
        logic     use_imm;  // second operand is imm, not rs2.
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rd_write;
        word_t    imm;      // already sign-extended.
        word_t    pc;
    } issue_t;

    typedef struct packed {
        logic     valid;
        logic     trap;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_value;
        word_t    rs2_value;
        reg_idx_t rd;
        logic     rd_write;
        word_t    result;
        word_t    pc;
    } stage_t;

    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
    } reg_write_t;

endpackage

// File: hdl/rv32_regfile.sv
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32_pkg::reg_idx_t   rs1,
    input  rv32_pkg::reg_idx_t   rs2,
    output rv32_pkg::word_t      rs1_value,
    output rv32_pkg::word_t      rs2_value,
    input  rv32_pkg::reg_write_t reg_write
);

    // x0 has no storage.
    rv32_pkg::word_t regs [1:rv32_pkg::REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < rv32_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.en && reg_write.addr != '0) begin
            regs[reg_write.addr] <= reg_write.data;
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];   // x0 reads zero.
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/rv32_trace_pkg.sv
package rv32_trace_pkg;

    localparam int         ORDER_W      = 64;
    localparam logic [1:0] MODE_MACHINE = 2'd3;

    // one rvfi style entry per retired instruction.
    typedef struct packed {
        logic                 valid;
        logic [ORDER_W-1:0]   order;
        logic                 trap;
        logic [1:0]           mode;
        rv32_pkg::reg_idx_t   rs1_addr;
        rv32_pkg::reg_idx_t   rs2_addr;
        rv32_pkg::word_t      rs1_rdata;
        rv32_pkg::word_t      rs2_rdata;
        rv32_pkg::reg_idx_t   rd_addr;
        rv32_pkg::word_t      rd_wdata;
        rv32_pkg::word_t      pc_rdata;
        rv32_pkg::word_t      pc_wdata;
    } retire_rec_t;

endpackage

// File: hdl/rv32_writeback.sv
`timescale 1ns/1ps

module rv32_writeback (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  rv32_pkg::stage_t            stage,
    output rv32_pkg::reg_write_t        reg_write,
    output rv32_trace_pkg::retire_rec_t retire
);

    logic                               commit;
    logic                               writes_rd;
    logic [rv32_trace_pkg::ORDER_W-1:0] order_cnt;

    assign commit    = stage.valid && !flush;   // flush kills the stage.
    assign writes_rd = stage.rd_write && !stage.trap;

    assign reg_write.en   = commit && writes_rd && (stage.rd != '0);
    assign reg_write.addr = stage.rd;
    assign reg_write.data = stage.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            order_cnt    <= '0;
            retire.valid <= 1'b0;
        end else if (commit) begin
            order_cnt    <= order_cnt + 1'b1;
            retire.valid <= 1'b1;
        end else begin
            retire.valid <= 1'b0;
        end

        if (commit) begin
            retire.order     <= order_cnt;   // count before increment.
            retire.trap      <= stage.trap;
            retire.mode      <= rv32_trace_pkg::MODE_MACHINE;
            retire.rs1_addr  <= stage.rs1;
            retire.rs2_addr  <= stage.rs2;
            retire.rs1_rdata <= stage.rs1_value;
            retire.rs2_rdata <= stage.rs2_value;
            retire.rd_addr   <= writes_rd ? stage.rd : '0;
            retire.rd_wdata  <= (writes_rd && stage.rd != '0) ? stage.result : '0;
            retire.pc_rdata  <= stage.pc;
            retire.pc_wdata  <= stage.pc + rv32_pkg::word_t'(4);
        end
    end

endmodule

// File: list.f
+incdir+test
hdl/rv32_pkg.sv
hdl/rv32_trace_pkg.sv
hdl/rv32_regfile.sv
hdl/rv32_execute.sv
hdl/rv32_writeback.sv
hdl/rv32_backend.sv
test/rv32_backend_tb.sv

// File: test/rv32_ref_model.svh
`ifndef RV32_REF_MODEL_SVH
`define RV32_REF_MODEL_SVH

// architectural state as the model sees it.
rv32_pkg::word_t                    model_regs [0:rv32_pkg::REG_COUNT-1];
rv32_pkg::stage_t                   model_slot;   // what the stage register should hold.
logic [rv32_trace_pkg::ORDER_W-1:0] model_order;
rv32_trace_pkg::retire_rec_t        exp_q [$];    // one expected record per cycle.

function automatic rv32_pkg::word_t alu_ref(input rv32_pkg::alu_op_t op,
                                            input rv32_pkg::word_t a,
                                            input rv32_pkg::word_t b);
    int unsigned     sh;
    rv32_pkg::word_t fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;   // sign bits shifted in.
    case (op)
        rv32_pkg::op_add:  return a + b;
        rv32_pkg::op_sub:  return a + ~b + 32'd1;
        rv32_pkg::op_and:  return a & b;
        rv32_pkg::op_or:   return a | b;
        rv32_pkg::op_xor:  return a ^ b;
        rv32_pkg::op_sll:  return a << sh;
        rv32_pkg::op_srl:  return a >> sh;
        rv32_pkg::op_sra:  return (a >> sh) | fill;
        rv32_pkg::op_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        rv32_pkg::op_sltu: return {31'b0, a < b};
        default:           return '0;
    endcase
endfunction

task automatic model_reset();
    for (int i = 0; i < rv32_pkg::REG_COUNT; i++) begin
        model_regs[i] = '0;
    end
    model_slot  = '0;
    model_order = '0;
    exp_q.delete();
    exp_q.push_back('0);   // nothing retires in the first cycle after reset.
endtask

// retire the slot and then read operands for the new issue, once per cycle.
task automatic model_step(input logic valid_in, input rv32_pkg::issue_t ins,
                          input logic flush_in);
    rv32_trace_pkg::retire_rec_t rec;
    rv32_pkg::word_t             b;
    logic                        writes;
    rec = '0;
    if (model_slot.valid && !flush_in) begin
        writes        = model_slot.rd_write && !model_slot.trap;
        rec.valid     = 1'b1;
        rec.order     = model_order;
        rec.trap      = model_slot.trap;
        rec.mode      = 2'd3;
        rec.rs1_addr  = model_slot.rs1;
        rec.rs2_addr  = model_slot.rs2;
        rec.rs1_rdata = model_slot.rs1_value;
        rec.rs2_rdata = model_slot.rs2_value;
        rec.rd_addr   = writes ? model_slot.rd : '0;
        rec.rd_wdata  = (writes && model_slot.rd != 0) ? model_slot.result : '0;
        rec.pc_rdata  = model_slot.pc;
        rec.pc_wdata  = model_slot.pc + 32'd4;
        model_order   = model_order + 1;
        if (writes && model_slot.rd != 0) begin
            model_regs[model_slot.rd] = model_slot.result;
        end
    end
    exp_q.push_back(rec);

    model_slot           = '0;
    model_slot.valid     = valid_in;
    model_slot.rs1       = ins.rs1;
    model_slot.rs2       = ins.rs2;
    model_slot.rs1_value = model_regs[ins.rs1];   // already holds this cycle's write.
    model_slot.rs2_value = model_regs[ins.rs2];
    model_slot.rd        = ins.rd;
    model_slot.rd_write  = ins.rd_write;
    model_slot.pc        = ins.pc;
    model_slot.trap      = (ins.op == rv32_pkg::op_illegal);
    b = ins.use_imm ? ins.imm : model_slot.rs2_value;
    model_slot.result = model_slot.trap ? '0 : alu_ref(ins.op, model_slot.rs1_value, b);
endtask

`endif

// File: test/rv32_backend_tb.sv
`timescale 1ns/1ps

module rv32_backend_tb;

    localparam int  NUM_SLOTS      = 2000;           // issue cycles after reset.
    localparam int  RESET_CYCLES   = 5;
    localparam int  TIMEOUT_CYCLES = NUM_SLOTS + 50;
    localparam time HALF_PERIOD    = 20ns;
    localparam time DRIVE_DELAY    = 2ns;

    logic                        clk;
    logic                        rst;
    logic                        issue_valid;
    rv32_pkg::issue_t            issue;
    logic                        flush;
    rv32_trace_pkg::retire_rec_t retire;

    int                          cycle_count;
    int                          error_count;
    rv32_pkg::word_t             next_pc;

    `include "rv32_ref_model.svh"

    rv32_backend uut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (flush),
        .retire      (retire)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: retire.%s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_retire(input rv32_trace_pkg::retire_rec_t got,
                                input rv32_trace_pkg::retire_rec_t exp);
        check_field("valid", got.valid, exp.valid);
        if (exp.valid) begin
            check_field("order", got.order, exp.order);
            check_field("trap", got.trap, exp.trap);
            check_field("mode", got.mode, exp.mode);
            check_field("rs1_addr", got.rs1_addr, exp.rs1_addr);
            check_field("rs2_addr", got.rs2_addr, exp.rs2_addr);
            check_field("rs1_rdata", got.rs1_rdata, exp.rs1_rdata);
            check_field("rs2_rdata", got.rs2_rdata, exp.rs2_rdata);
            check_field("rd_addr", got.rd_addr, exp.rd_addr);
            check_field("rd_wdata", got.rd_wdata, exp.rd_wdata);
            check_field("pc_rdata", got.pc_rdata, exp.pc_rdata);
            check_field("pc_wdata", got.pc_wdata, exp.pc_wdata);
        end
    endtask

    // small index pool most of the time, so results get reused.
    function automatic rv32_pkg::reg_idx_t pick_reg();
        if ($urandom_range(0, 3) == 0) begin
            return rv32_pkg::reg_idx_t'($urandom_range(0, 31));
        end
        return rv32_pkg::reg_idx_t'($urandom_range(0, 5));
    endfunction

    task automatic drive_random();
        rv32_pkg::issue_t ins;
        int unsigned      pick;
        rv32_pkg::word_t  raw;
        pick = $urandom_range(0, 63);
        if (pick == 0) begin
            ins.op = rv32_pkg::op_illegal;   // rare.
        end else begin
            ins.op = rv32_pkg::alu_op_t'(pick % 10);
        end
        ins.use_imm  = $urandom_range(0, 1);
        ins.rs1      = pick_reg();
        ins.rs2      = pick_reg();
        ins.rd       = pick_reg();
        ins.rd_write = ($urandom_range(0, 7) != 0);
        raw          = $urandom();
        ins.imm      = (raw[31:30] == 2'b00) ? raw : {{20{raw[11]}}, raw[11:0]};
        ins.pc       = next_pc;
        issue        = ins;
        issue_valid  = ($urandom_range(0, 3) != 0);
        flush        = ($urandom_range(0, 7) == 0);
        if (issue_valid) begin
            next_pc = next_pc + 32'd4;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        flush       = 1'b0;
        cycle_count = 0;
        error_count = 0;
        next_pc     = 32'h0000_1000;
        void'($urandom(16));
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (int n = 0; n < NUM_SLOTS; n++) begin
            check_retire(retire, exp_q.pop_front());
            drive_random();
            model_step(issue_valid, issue, flush);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        // let the last instructions drain out.
        issue_valid = 1'b0;
        flush       = 1'b0;
        repeat (3) begin
            check_retire(retire, exp_q.pop_front());
            model_step(1'b0, issue, 1'b0);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "simulation stopped");
        end
    end

endmodule
